/* source/game_pkg.sv */
`default_nettype none

package game_pkg;

    // signed pixel coordinates, wide enough for positions partly off screen
    localparam int PIXEL_WIDTH = 11;

    // positions are kept at 1/64 pixel, so the shift is 6
    localparam int FIXED_SHIFT = 6;

    // bit positions inside the edge code and the blocking flags
    localparam int EDGE_LEFT   = 3;
    localparam int EDGE_TOP    = 2;
    localparam int EDGE_RIGHT  = 1;
    localparam int EDGE_BOTTOM = 0;

    // rgb332 style colour word
    localparam int COLOR_WIDTH = 8;

    localparam logic [COLOR_WIDTH-1:0] COLOR_BG     = 8'h00;
    localparam logic [COLOR_WIDTH-1:0] COLOR_WALL   = 8'he0;
    localparam logic [COLOR_WIDTH-1:0] COLOR_PLAYER = 8'h1c;

    // collision vector slot for player against wall
    // remaining slots are reserved and read zero
    localparam int COLL_PLAYER_WALL = 3;

endpackage

`default_nettype wire

/* source/pixel_scan.sv */
`default_nettype none

module pixel_scan
    import game_pkg::*;
#(
    parameter int SCREEN_W = 64,
    parameter int SCREEN_H = 48
) (
    input  logic                          clk,
    input  logic                          resetN,
    output logic signed [PIXEL_WIDTH-1:0] pixel_x,
    output logic signed [PIXEL_WIDTH-1:0] pixel_y,
    output logic                          start_of_frame
);

    // last column and row of the active area
    localparam logic signed [PIXEL_WIDTH-1:0] LAST_X = PIXEL_WIDTH'(SCREEN_W - 1);
    localparam logic signed [PIXEL_WIDTH-1:0] LAST_Y = PIXEL_WIDTH'(SCREEN_H - 1);

    logic x_wrap;
    logic y_wrap;

    // wrap conditions of the current pixel
    assign x_wrap = (pixel_x == LAST_X);
    assign y_wrap = (pixel_y == LAST_Y);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pixel_x        <= '0;
            pixel_y        <= '0;
            // first cycle out of reset shows pixel (0,0)
            start_of_frame <= 1'b1;
        end else begin
            // column advances every clock
            if (x_wrap) begin
                pixel_x <= '0;
            end else begin
                pixel_x <= pixel_x + 1'b1;
            end

            // row advances on each column wrap
            if (x_wrap) begin
                if (y_wrap) begin
                    pixel_y <= '0;
                end else begin
                    pixel_y <= pixel_y + 1'b1;
                end
            end

            // strobe lands together with the next (0,0)
            start_of_frame <= x_wrap && y_wrap;
        end
    end

endmodule

`default_nettype wire

/* source/player_move.sv */
`default_nettype none

module player_move
    import game_pkg::*;
#(
    parameter int INITIAL_X = 20,
    parameter int INITIAL_Y = 20,
    parameter int X_SPEED   = 128,
    parameter int Y_SPEED   = 128
) (
    input  logic                          clk,
    input  logic                          resetN,
    input  logic                          start_of_frame,
    input  logic                          move_left,
    input  logic                          move_right,
    input  logic                          move_up,
    input  logic                          move_down,
    input  logic [3:0]                    collision,
    input  logic [3:0]                    hit_edge_code,
    output logic signed [PIXEL_WIDTH-1:0] top_left_x,
    output logic signed [PIXEL_WIDTH-1:0] top_left_y
);

    // fixed point word holds the pixel part plus the fraction bits
    localparam int FP_WIDTH = PIXEL_WIDTH + FIXED_SHIFT;

    localparam logic signed [FP_WIDTH-1:0] INIT_X_FP = FP_WIDTH'(INITIAL_X * (1 << FIXED_SHIFT));
    localparam logic signed [FP_WIDTH-1:0] INIT_Y_FP = FP_WIDTH'(INITIAL_Y * (1 << FIXED_SHIFT));

    logic signed [FP_WIDTH-1:0] x_fp;
    logic signed [FP_WIDTH-1:0] y_fp;
    logic signed [FP_WIDTH-1:0] x_speed;
    logic signed [FP_WIDTH-1:0] y_speed;

    // sides that touched the wall during the current frame
    logic [3:0] block_flags;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            x_speed     <= '0;
            y_speed     <= '0;
            x_fp        <= INIT_X_FP;
            y_fp        <= INIT_Y_FP;
            block_flags <= '0;
        end else begin
            // horizontal speed, only one button may be held
            if (move_right && !move_left && !block_flags[EDGE_RIGHT]) begin
                x_speed <= FP_WIDTH'(X_SPEED);
            end else if (move_left && !move_right && !block_flags[EDGE_LEFT]) begin
                x_speed <= FP_WIDTH'(-X_SPEED);
            end else begin
                x_speed <= '0;
            end

            // vertical speed, y grows downward
            if (move_down && !move_up && !block_flags[EDGE_BOTTOM]) begin
                y_speed <= FP_WIDTH'(Y_SPEED);
            end else if (move_up && !move_down && !block_flags[EDGE_TOP]) begin
                y_speed <= FP_WIDTH'(-Y_SPEED);
            end else begin
                y_speed <= '0;
            end

            // frame step, flags start over for the new frame
            if (start_of_frame) begin
                x_fp        <= x_fp + x_speed;
                y_fp        <= y_fp + y_speed;
                block_flags <= '0;
            end else if (collision[COLL_PLAYER_WALL]) begin
                // collect every edge that met the wall
                block_flags <= block_flags | hit_edge_code;
            end
        end
    end

    // drop the fraction, sign kept for off screen positions
    assign top_left_x = PIXEL_WIDTH'(x_fp >>> FIXED_SHIFT);
    assign top_left_y = PIXEL_WIDTH'(y_fp >>> FIXED_SHIFT);

endmodule

`default_nettype wire

/* source/player_draw.sv */
`default_nettype none

module player_draw
    import game_pkg::*;
#(
    parameter int PLAYER_SIZE = 8
) (
    input  logic signed [PIXEL_WIDTH-1:0] pixel_x,
    input  logic signed [PIXEL_WIDTH-1:0] pixel_y,
    input  logic signed [PIXEL_WIDTH-1:0] top_left_x,
    input  logic signed [PIXEL_WIDTH-1:0] top_left_y,
    output logic                          player_dr,
    output logic [3:0]                    hit_edge_code
);

    // one extra bit so the difference cannot overflow
    logic signed [PIXEL_WIDTH:0] offset_x;
    logic signed [PIXEL_WIDTH:0] offset_y;

    logic inside_x;
    logic inside_y;

    // position of the scanned pixel relative to the corner
    assign offset_x = pixel_x - top_left_x;
    assign offset_y = pixel_y - top_left_y;

    assign inside_x = (offset_x >= 0) && (offset_x < PLAYER_SIZE);
    assign inside_y = (offset_y >= 0) && (offset_y < PLAYER_SIZE);

    // draw request covers the whole square
    assign player_dr = inside_x && inside_y;

    always_comb begin
        hit_edge_code = '0;
        if (player_dr) begin
            // first and last column
            if (offset_x == 0) begin
                hit_edge_code[EDGE_LEFT] = 1'b1;
            end
            if (offset_x == PLAYER_SIZE - 1) begin
                hit_edge_code[EDGE_RIGHT] = 1'b1;
            end
            // first and last row, corners end up with two bits
            if (offset_y == 0) begin
                hit_edge_code[EDGE_TOP] = 1'b1;
            end
            if (offset_y == PLAYER_SIZE - 1) begin
                hit_edge_code[EDGE_BOTTOM] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/border_draw.sv */
`default_nettype none

module border_draw
    import game_pkg::*;
#(
    parameter int SCREEN_W = 64,
    parameter int SCREEN_H = 48,
    parameter int BORDER_W = 2
) (
    input  logic signed [PIXEL_WIDTH-1:0] pixel_x,
    input  logic signed [PIXEL_WIDTH-1:0] pixel_y,
    output logic                          wall_dr
);

    // first column and row of the right and bottom walls
    localparam int RIGHT_WALL  = SCREEN_W - BORDER_W;
    localparam int BOTTOM_WALL = SCREEN_H - BORDER_W;

    logic in_left;
    logic in_right;
    logic in_top;
    logic in_bottom;

    // one band per screen side
    assign in_left   = (pixel_x < BORDER_W);
    assign in_right  = (pixel_x >= RIGHT_WALL);
    assign in_top    = (pixel_y < BORDER_W);
    assign in_bottom = (pixel_y >= BOTTOM_WALL);

    // the four bands overlap at the corners and close the frame
    assign wall_dr = in_left || in_right || in_top || in_bottom;

endmodule

`default_nettype wire

/* source/game_controller.sv */
`default_nettype none

module game_controller
    import game_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   start_of_frame,
    input  logic                   btn_left,
    input  logic                   btn_right,
    input  logic                   btn_up,
    input  logic                   btn_down,
    input  logic                   player_dr,
    input  logic                   wall_dr,
    input  logic [3:0]             hit_edge_code,
    output logic                   move_left,
    output logic                   move_right,
    output logic                   move_up,
    output logic                   move_down,
    output logic [3:0]             collision,
    output logic [COLOR_WIDTH-1:0] rgb,
    output logic [15:0]            hit_frames
);

    logic player_pixel;
    logic frame_hit;

    // edge pixels of the square always count as player
    assign player_pixel = player_dr || (hit_edge_code != 4'b0000);

    // player over wall in the current pixel
    always_comb begin
        collision                   = '0;
        collision[COLL_PLAYER_WALL] = player_pixel && wall_dr;
    end

    // priority is player, then wall, then background
    always_comb begin
        if (player_pixel) begin
            rgb = COLOR_PLAYER;
        end else if (wall_dr) begin
            rgb = COLOR_WALL;
        end else begin
            rgb = COLOR_BG;
        end
    end

    // buttons are held steady for a whole frame
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            move_left  <= 1'b0;
            move_right <= 1'b0;
            move_up    <= 1'b0;
            move_down  <= 1'b0;
        end else if (start_of_frame) begin
            move_left  <= btn_left;
            move_right <= btn_right;
            move_up    <= btn_up;
            move_down  <= btn_down;
        end
    end

    // count frames that saw at least one hit
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            frame_hit  <= 1'b0;
            hit_frames <= '0;
        end else if (start_of_frame) begin
            if (frame_hit) begin
                hit_frames <= hit_frames + 16'd1;
            end
            // clear has priority over a hit in the strobe cycle
            frame_hit <= 1'b0;
        end else if (collision[COLL_PLAYER_WALL]) begin
            frame_hit <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/game_top.sv */
`default_nettype none

module game_top
    import game_pkg::*;
#(
    parameter int SCREEN_W    = 64,
    parameter int SCREEN_H    = 48,
    parameter int BORDER_W    = 2,
    parameter int PLAYER_SIZE = 8,
    parameter int INITIAL_X   = 20,
    parameter int INITIAL_Y   = 20,
    parameter int X_SPEED     = 128,
    parameter int Y_SPEED     = 128
) (
    input  logic                          clk,
    input  logic                          resetN,
    input  logic                          btn_left,
    input  logic                          btn_right,
    input  logic                          btn_up,
    input  logic                          btn_down,
    output logic signed [PIXEL_WIDTH-1:0] pixel_x,
    output logic signed [PIXEL_WIDTH-1:0] pixel_y,
    output logic signed [PIXEL_WIDTH-1:0] top_left_x,
    output logic signed [PIXEL_WIDTH-1:0] top_left_y,
    output logic                          start_of_frame,
    output logic [COLOR_WIDTH-1:0]        rgb,
    output logic [15:0]                   hit_frames
);

    // draw requests and edge code of the current pixel
    logic       player_dr;
    logic       wall_dr;
    logic [3:0] hit_edge_code;
    logic [3:0] collision;

    // buttons as sampled at the last frame start
    logic move_left;
    logic move_right;
    logic move_up;
    logic move_down;

    // raster position and frame strobe
    pixel_scan #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_pixel_scan (
        .clk            (clk),
        .resetN         (resetN),
        .pixel_x        (pixel_x),
        .pixel_y        (pixel_y),
        .start_of_frame (start_of_frame)
    );

    // square position, stepped once per frame
    player_move #(
        .INITIAL_X (INITIAL_X),
        .INITIAL_Y (INITIAL_Y),
        .X_SPEED   (X_SPEED),
        .Y_SPEED   (Y_SPEED)
    ) u_player_move (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .move_left      (move_left),
        .move_right     (move_right),
        .move_up        (move_up),
        .move_down      (move_down),
        .collision      (collision),
        .hit_edge_code  (hit_edge_code),
        .top_left_x     (top_left_x),
        .top_left_y     (top_left_y)
    );

    player_draw #(
        .PLAYER_SIZE (PLAYER_SIZE)
    ) u_player_draw (
        .pixel_x       (pixel_x),
        .pixel_y       (pixel_y),
        .top_left_x    (top_left_x),
        .top_left_y    (top_left_y),
        .player_dr     (player_dr),
        .hit_edge_code (hit_edge_code)
    );

    border_draw #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H),
        .BORDER_W (BORDER_W)
    ) u_border_draw (
        .pixel_x (pixel_x),
        .pixel_y (pixel_y),
        .wall_dr (wall_dr)
    );

    // buttons, hits and colour
    game_controller u_game_controller (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame),
        .btn_left       (btn_left),
        .btn_right      (btn_right),
        .btn_up         (btn_up),
        .btn_down       (btn_down),
        .player_dr      (player_dr),
        .wall_dr        (wall_dr),
        .hit_edge_code  (hit_edge_code),
        .move_left      (move_left),
        .move_right     (move_right),
        .move_up        (move_up),
        .move_down      (move_down),
        .collision      (collision),
        .rgb            (rgb),
        .hit_frames     (hit_frames)
    );

endmodule

`default_nettype wire

/* sim/game_checker.sv */
`default_nettype none

module game_checker
    import game_pkg::*;
(
    input logic                          clk,
    input logic                          resetN,
    input logic signed [PIXEL_WIDTH-1:0] pixel_x,
    input logic signed [PIXEL_WIDTH-1:0] pixel_y,
    input logic signed [PIXEL_WIDTH-1:0] top_left_x,
    input logic signed [PIXEL_WIDTH-1:0] top_left_y,
    input logic                          start_of_frame,
    input logic [15:0]                   hit_frames
);

    // number of failed assertions
    int assert_fails = 0;

    // strobe only on the first pixel of the raster
    a_strobe_origin: assert property (@(posedge clk) disable iff (!resetN)
        start_of_frame |-> (pixel_x == 0 && pixel_y == 0))
        else begin
            $error("start_of_frame high away from pixel (0,0)");
            assert_fails++;
        end

    // the square only steps at a frame start
    a_move_on_strobe: assert property (@(posedge clk) disable iff (!resetN)
        (!$stable(top_left_x) || !$stable(top_left_y)) |-> $past(start_of_frame))
        else begin
            $error("player position changed outside the cycle after a strobe");
            assert_fails++;
        end

    // hit counter only counts up
    a_hits_monotonic: assert property (@(posedge clk) disable iff (!resetN)
        hit_frames >= $past(hit_frames))
        else begin
            $error("hit_frames decreased");
            assert_fails++;
        end

endmodule

bind game_top game_checker u_game_checker (
    .clk            (clk),
    .resetN         (resetN),
    .pixel_x        (pixel_x),
    .pixel_y        (pixel_y),
    .top_left_x     (top_left_x),
    .top_left_y     (top_left_y),
    .start_of_frame (start_of_frame),
    .hit_frames     (hit_frames)
);

`default_nettype wire

/* sim/game_tb.sv */
`default_nettype none

module game_tb
    import game_pkg::*;
();

    localparam int SCREEN_W     = 64;
    localparam int SCREEN_H     = 48;
    localparam int BORDER_W     = 2;
    localparam int PLAYER_SIZE  = 8;
    localparam int INITIAL_X    = 20;
    localparam int INITIAL_Y    = 20;
    localparam int X_SPEED      = 128;
    localparam int Y_SPEED      = 128;
    localparam int FRAME_CYCLES = SCREEN_W * SCREEN_H;
    // pixels per frame step on each axis
    localparam int STEP_X = X_SPEED / (1 << FIXED_SHIFT);
    localparam int STEP_Y = Y_SPEED / (1 << FIXED_SHIFT);

    // frames of reset, free motion, walls, colour and random play
    localparam int FRAMES_RUN     = 2 + 23 + 104 + 6 + 42;
    localparam int TIMEOUT_CYCLES = (FRAMES_RUN + 4) * FRAME_CYCLES + 10;

    // button word in edge bit order
    localparam logic [3:0] B_NONE  = 4'b0000;
    localparam logic [3:0] B_LEFT  = 4'b1000;
    localparam logic [3:0] B_UP    = 4'b0100;
    localparam logic [3:0] B_RIGHT = 4'b0010;
    localparam logic [3:0] B_DOWN  = 4'b0001;

    logic clk;
    logic resetN;
    logic btn_left;
    logic btn_right;
    logic btn_up;
    logic btn_down;
    logic signed [PIXEL_WIDTH-1:0] pixel_x;
    logic signed [PIXEL_WIDTH-1:0] pixel_y;
    logic signed [PIXEL_WIDTH-1:0] top_left_x;
    logic signed [PIXEL_WIDTH-1:0] top_left_y;
    logic start_of_frame;
    logic [COLOR_WIDTH-1:0] rgb;
    logic [15:0] hit_frames;

    // model state, positions in 1/64 pixel
    int m_x_fp;
    int m_y_fp;
    logic [3:0] m_btn;
    logic [3:0] cur_btn;
    int m_hits;
    int cycle_count;
    int last_strobe;
    int last_period;
    int errors;
    int test_errors;
    int checks;
    string test_name;
    logic [31:0] lcg_state;

    game_top #(
        .SCREEN_W (SCREEN_W), .SCREEN_H (SCREEN_H), .BORDER_W (BORDER_W),
        .PLAYER_SIZE (PLAYER_SIZE), .INITIAL_X (INITIAL_X), .INITIAL_Y (INITIAL_Y),
        .X_SPEED (X_SPEED), .Y_SPEED (Y_SPEED)
    ) u_game_top (
        .clk (clk), .resetN (resetN),
        .btn_left (btn_left), .btn_right (btn_right), .btn_up (btn_up), .btn_down (btn_down),
        .pixel_x (pixel_x), .pixel_y (pixel_y),
        .top_left_x (top_left_x), .top_left_y (top_left_y),
        .start_of_frame (start_of_frame), .rgb (rgb), .hit_frames (hit_frames)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // wall band of the frame, on screen pixels only
    function automatic bit on_wall(input int px, input int py);
        if (px < 0 || px >= SCREEN_W || py < 0 || py >= SCREEN_H)
            return 1'b0;
        return px < BORDER_W || px >= SCREEN_W - BORDER_W
            || py < BORDER_W || py >= SCREEN_H - BORDER_W;
    endfunction

    function automatic bit touches(input logic [3:0] side, input int x, input int y);
        case (side)
            B_RIGHT: return x + PLAYER_SIZE - 1 >= SCREEN_W - BORDER_W;
            B_LEFT:  return x < BORDER_W;
            B_DOWN:  return y + PLAYER_SIZE - 1 >= SCREEN_H - BORDER_W;
            default: return y < BORDER_W;
        endcase
    endfunction

    // one frame of the square at (x,y), edges that met the wall and any hit
    task automatic scan_frame(input int x, input int y, output logic [3:0] edges,
                              output bit hit);
        int px;
        int py;
        edges = '0;
        hit   = 1'b0;
        for (int dy = 0; dy < PLAYER_SIZE; dy++) begin
            for (int dx = 0; dx < PLAYER_SIZE; dx++) begin
                px = x + dx;
                py = y + dy;
                // pixel (0,0) is shown in the strobe cycle, which clears the flags
                if (on_wall(px, py) && !(px == 0 && py == 0)) begin
                    hit = 1'b1;
                    edges[EDGE_LEFT]   |= (dx == 0);
                    edges[EDGE_RIGHT]  |= (dx == PLAYER_SIZE - 1);
                    edges[EDGE_TOP]    |= (dy == 0);
                    edges[EDGE_BOTTOM] |= (dy == PLAYER_SIZE - 1);
                end
            end
        end
    endtask

    task automatic drive_buttons(input logic [3:0] btn);
        cur_btn   = btn;
        btn_left  = btn[EDGE_LEFT];
        btn_right = btn[EDGE_RIGHT];
        btn_up    = btn[EDGE_TOP];
        btn_down  = btn[EDGE_BOTTOM];
    endtask

    // called at the falling edge inside a strobe cycle
    task automatic process_strobe(input logic [3:0] btn);
        logic [3:0] edges;
        bit hit;
        last_period = cycle_count - last_strobe;
        last_strobe = cycle_count;
        // the frame that ends here decides the blocking and the hit
        scan_frame(m_x_fp >>> FIXED_SHIFT, m_y_fp >>> FIXED_SHIFT, edges, hit);
        if (m_btn[EDGE_RIGHT] && !m_btn[EDGE_LEFT] && !edges[EDGE_RIGHT])
            m_x_fp += X_SPEED;
        else if (m_btn[EDGE_LEFT] && !m_btn[EDGE_RIGHT] && !edges[EDGE_LEFT])
            m_x_fp -= X_SPEED;
        if (m_btn[EDGE_BOTTOM] && !m_btn[EDGE_TOP] && !edges[EDGE_BOTTOM])
            m_y_fp += Y_SPEED;
        else if (m_btn[EDGE_TOP] && !m_btn[EDGE_BOTTOM] && !edges[EDGE_TOP])
            m_y_fp -= Y_SPEED;
        m_hits += int'(hit);
        // buttons on the pins now are taken at this strobe
        m_btn = cur_btn;
        @(posedge clk);
        @(negedge clk);
        check_value("top_left_x", m_x_fp >>> FIXED_SHIFT, top_left_x);
        check_value("top_left_y", m_y_fp >>> FIXED_SHIFT, top_left_y);
        check_value("hit_frames", m_hits, hit_frames);
        drive_buttons(btn);
    endtask

    task automatic check_pixel();
        int x;
        int y;
        int px;
        int py;
        int offset;
        logic [COLOR_WIDTH-1:0] expected;
        x      = m_x_fp >>> FIXED_SHIFT;
        y      = m_y_fp >>> FIXED_SHIFT;
        // raster position counted from the last strobe
        offset = cycle_count - last_strobe;
        px     = offset % SCREEN_W;
        py     = offset / SCREEN_W;
        check_value("pixel_x", px, pixel_x);
        check_value("pixel_y", py, pixel_y);
        if (px >= x && px < x + PLAYER_SIZE && py >= y && py < y + PLAYER_SIZE)
            expected = COLOR_PLAYER;
        else if (on_wall(px, py))
            expected = COLOR_WALL;
        else
            expected = COLOR_BG;
        check_value("rgb", expected, rgb);
    endtask

    // hold btn for a number of frames, optionally checking rgb at random pixels
    task automatic run_frames(input logic [3:0] btn, input int frames, input bit check_rgb);
        int done;
        done = 0;
        while (done < frames) begin
            @(negedge clk);
            if (start_of_frame) begin
                process_strobe(btn);
                done++;
            end else if (check_rgb && (lcg_next() >> 29) == 0) begin
                check_pixel();
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0)
            $display("test %s: ok", test_name);
        else
            $display("test %s: %0d errors", test_name, test_errors);
    endtask

    // drive into one wall, then back off from it
    task automatic wall_side(input string name, input logic [3:0] toward,
                             input logic [3:0] away, input int frames,
                             input int dx, input int dy);
        int sx;
        int sy;
        start_test(name);
        run_frames(toward, frames, 1'b0);
        run_frames(B_NONE, 2, 1'b0);
        sx = top_left_x;
        sy = top_left_y;
        check_value("contact", 1, touches(toward, sx, sy));
        run_frames(away, 2, 1'b0);
        run_frames(B_NONE, 2, 1'b0);
        check_value("release x", sx + dx, top_left_x);
        check_value("release y", sy + dy, top_left_y);
        end_test();
    endtask

    initial begin
        int x0;
        int y0;
        clk         = 1'b0;
        resetN      = 1'b0;
        drive_buttons(B_NONE);
        lcg_state   = 32'haa77_3749;
        m_x_fp      = INITIAL_X * (1 << FIXED_SHIFT);
        m_y_fp      = INITIAL_Y * (1 << FIXED_SHIFT);
        m_btn       = B_NONE;
        m_hits      = 0;
        cycle_count = 0;
        last_strobe = 0;
        errors      = 0;
        checks      = 0;
        repeat (10) @(negedge clk);
        resetN = 1'b1;

        start_test("reset");
        check_value("start_of_frame", 1, start_of_frame);
        check_value("pixel_x", 0, pixel_x);
        check_value("pixel_y", 0, pixel_y);
        check_value("top_left_x", INITIAL_X, top_left_x);
        check_value("top_left_y", INITIAL_Y, top_left_y);
        check_value("hit_frames", 0, hit_frames);
        process_strobe(B_NONE);
        run_frames(B_NONE, 1, 1'b0);
        check_value("frame period", FRAME_CYCLES, last_period);
        end_test();

        start_test("free motion");
        run_frames(B_NONE, 2, 1'b0);
        x0 = top_left_x;
        y0 = top_left_y;
        // taken at the second strobe, so no step yet
        run_frames(B_RIGHT, 2, 1'b0);
        check_value("right after sampling", x0, top_left_x);
        run_frames(B_RIGHT, 2, 1'b0);
        run_frames(B_NONE, 2, 1'b0);
        check_value("right x", x0 + 4 * STEP_X, top_left_x);
        run_frames(B_LEFT | B_RIGHT, 3, 1'b0);
        run_frames(B_NONE, 2, 1'b0);
        check_value("left and right x", x0 + 4 * STEP_X, top_left_x);
        run_frames(B_DOWN, 3, 1'b0);
        run_frames(B_NONE, 2, 1'b0);
        check_value("down y", y0 + 3 * STEP_Y, top_left_y);
        check_value("idle x", x0 + 4 * STEP_X, top_left_x);
        run_frames(B_UP | B_DOWN, 3, 1'b0);
        run_frames(B_NONE, 2, 1'b0);
        check_value("up and down y", y0 + 3 * STEP_Y, top_left_y);
        end_test();

        wall_side("wall right", B_RIGHT, B_LEFT, 18, -2 * STEP_X, 0);
        wall_side("wall left", B_LEFT, B_RIGHT, 30, 2 * STEP_X, 0);
        wall_side("wall bottom", B_DOWN, B_UP, 10, 0, -2 * STEP_Y);
        wall_side("wall top", B_UP, B_DOWN, 22, 0, 2 * STEP_Y);

        // square pushed into the top wall so all three colours show
        start_test("colour");
        run_frames(B_UP, 2, 1'b0);
        run_frames(B_NONE, 2, 1'b0);
        run_frames(B_NONE, 2, 1'b1);
        end_test();

        start_test("random play");
        for (int i = 0; i < 40; i++) begin
            run_frames(4'(lcg_next() >> 28), 1, 1'b0);
        end
        run_frames(B_NONE, 2, 1'b0);
        end_test();

        errors += u_game_top.u_game_checker.assert_fails;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_game_top.u_game_checker.assert_fails);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/game_pkg.sv
source/pixel_scan.sv
source/player_move.sv
source/player_draw.sv
source/border_draw.sv
source/game_controller.sv
source/game_top.sv
sim/game_checker.sv
sim/game_tb.sv
